//--- Makefile
# Verilator build and run of the fork-join pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_fork_join
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/checksum_lane.sv
// --------------------------------------------------------------------------
// Checksum lane
// Stage 1 adds the four bytes into a 10-bit sum. Stage 2 folds the upper
// bits back in twice, end-around style, and inverts the result into an
// 8-bit ones'-complement checksum
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

module checksum_lane (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  fj_pkg::word_u         in_word,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [`FJ_CSUM_W-1:0] out_csum
);

  fj_pkg::sum_t          s1_in;
  fj_pkg::sum_t          s1_out;
  logic                  s1_valid;
  logic                  s1_ready;
  logic [`FJ_CSUM_W:0]   fold1;
  logic [`FJ_CSUM_W-1:0] fold2;
  logic [`FJ_CSUM_W-1:0] csum;

  // ------------------------------------------------------------------------
  // Stage 1 byte sum
  // ------------------------------------------------------------------------
  always_comb begin
    s1_in.sum = '0;
    for (int i = 0; i < `FJ_NUM_BYTES; i++) begin
      s1_in.sum = s1_in.sum + `FJ_SUM_W'(in_word.bytes[i]);
    end
  end

  pipe_stage #(.Width($bits(fj_pkg::sum_t))) u_s1 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (s1_in),
    .out_valid (s1_valid),
    .out_ready (s1_ready),
    .out_data  (s1_out)
  );

  // ------------------------------------------------------------------------
  // Stage 2 fold and invert
  // ------------------------------------------------------------------------
  always_comb begin
    // Upper two sum bits wrap into the low byte
    fold1 = {1'b0, s1_out.sum[`FJ_CSUM_W-1:0]} +
            (`FJ_CSUM_W + 1)'(s1_out.sum[`FJ_SUM_W-1:`FJ_CSUM_W]);
    // Carry out of bit 7 wraps once more and cannot carry again
    fold2 = fold1[`FJ_CSUM_W-1:0] + `FJ_CSUM_W'(fold1[`FJ_CSUM_W]);
    csum  = ~fold2;
  end

  pipe_stage #(.Width(`FJ_CSUM_W)) u_s2 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s1_valid),
    .in_ready  (s1_ready),
    .in_data   (csum),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_csum)
  );

  // Four bytes can never add past 4 * 255
  sum_range_a : assert property (@(posedge clk) disable iff (rst)
    s1_valid |-> s1_out.sum <= `FJ_SUM_W'(4 * 255));

endmodule

`default_nettype wire

//--- hw/fj_params.svh
// --------------------------------------------------------------------------
// Fork-join word statistics, global sizing
// Word width, byte count and the widths of the derived statistics
// --------------------------------------------------------------------------

`ifndef FJ_PARAMS_SVH
`define FJ_PARAMS_SVH

// Input word width in bits
`define FJ_WORD_W 32
// Bytes per word, byte 0 is least significant
`define FJ_NUM_BYTES (`FJ_WORD_W / 8)
// Set-bit count, wide enough to hold FJ_WORD_W itself
`define FJ_CNT_W 6
// Raw byte sum, four bytes of 255 fit in 10 bits
`define FJ_SUM_W 10
// Folded ones'-complement checksum
`define FJ_CSUM_W 8

`endif

//--- hw/fj_pkg.sv
// --------------------------------------------------------------------------
// Fork-join word statistics, shared types
// Input word views, lane payloads and the joined result record
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

package fj_pkg;

  // ------------------------------------------------------------------------
  // Input word
  // ------------------------------------------------------------------------

  // Same word seen whole by the popcount lane, per byte by the checksum lane
  typedef union packed {
    logic [`FJ_WORD_W-1:0]         raw;
    logic [`FJ_NUM_BYTES-1:0][7:0] bytes;
  } word_u;

  // ------------------------------------------------------------------------
  // Lane payloads
  // ------------------------------------------------------------------------

  // Popcount lane record, 39 bits
  typedef struct packed {
    logic [`FJ_WORD_W-1:0] word;
    logic [`FJ_CNT_W-1:0]  count;
    logic                  parity;  // set when count is odd
  } pop_t;

  // Unfolded byte sum between the two checksum stages
  typedef struct packed {
    logic [`FJ_SUM_W-1:0] sum;
  } sum_t;

  // ------------------------------------------------------------------------
  // Output record, 47 bits
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [`FJ_WORD_W-1:0] word;
    logic [`FJ_CNT_W-1:0]  count;
    logic                  parity;
    logic [`FJ_CSUM_W-1:0] csum;
  } result_t;

endpackage

`default_nettype wire

//--- hw/flow_fork.sv
// --------------------------------------------------------------------------
// Two-way ready/valid flow fork
// Hands one upstream stream to two lanes that must both take it on the
// same edge. Control only, the word travels to the lanes on its own bus
// --------------------------------------------------------------------------

`default_nettype none

module flow_fork (
  // Clock and reset feed the assertions only
  input  logic       clk,
  input  logic       rst,
  // Upstream side
  input  logic       push_valid,
  output logic       push_ready,
  // Lane side, bit 0 popcount lane, bit 1 checksum lane
  input  logic [1:0] pop_ready,
  // A lane valid can drop when the other lane's ready drops,
  // no lane valid depends on that lane's own ready
  output logic [1:0] pop_valid_unstable
);

  // ------------------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------------------

  // Upstream moves only when every lane can take the word
  assign push_ready = &pop_ready;

  // Each lane sees valid only while the other lane is ready
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      pop_valid_unstable[i] = push_valid && pop_ready[1 - i];
    end
  end

  // ------------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------------

  // Upstream must not withdraw a stalled word
  push_hold_a : assert property (@(posedge clk) disable iff (rst)
    push_valid && !push_ready |=> push_valid);

  // No lane ever sees a word that upstream did not offer
  no_phantom_a : assert property (@(posedge clk) disable iff (rst)
    !push_valid |-> pop_valid_unstable == 2'b00);

endmodule

`default_nettype wire

//--- hw/fork_join_top.sv
// --------------------------------------------------------------------------
// Fork-join word statistics pipeline
// Input register, two-way fork into popcount and checksum lanes, and a
// joining output register. Three cycles from input accept to out_valid
// when nothing back-pressures
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

module fork_join_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  fj_pkg::word_u   in_word,
  output logic            out_valid,
  input  logic            out_ready,
  output fj_pkg::result_t out_result
);

  fj_pkg::word_u         stage_word;
  fj_pkg::pop_t          pop_data;
  logic                  stage_valid;
  logic                  stage_ready;
  logic [1:0]            lane_valid;
  logic [1:0]            lane_ready;
  logic                  pop_valid;
  logic                  pop_ready;
  logic                  csum_valid;
  logic                  csum_ready;
  logic [`FJ_CSUM_W-1:0] csum_data;

  pipe_stage #(.Width($bits(fj_pkg::word_u))) u_in_stage (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_data(in_word),
    .out_valid(stage_valid), .out_ready(stage_ready), .out_data(stage_word)
  );

  // Lane 0 popcount, lane 1 checksum
  flow_fork u_fork (
    .clk(clk), .rst(rst),
    .push_valid(stage_valid), .push_ready(stage_ready),
    .pop_ready(lane_ready), .pop_valid_unstable(lane_valid)
  );

  // Held word fans out to both lanes
  popcount_lane u_pop (
    .clk(clk), .rst(rst),
    .in_valid(lane_valid[0]), .in_ready(lane_ready[0]), .in_word(stage_word),
    .out_valid(pop_valid), .out_ready(pop_ready), .out_pop(pop_data)
  );

  checksum_lane u_csum (
    .clk(clk), .rst(rst),
    .in_valid(lane_valid[1]), .in_ready(lane_ready[1]), .in_word(stage_word),
    .out_valid(csum_valid), .out_ready(csum_ready), .out_csum(csum_data)
  );

  out_stage u_out (
    .clk(clk), .rst(rst),
    .a_valid(pop_valid), .a_ready(pop_ready), .a_pop(pop_data),
    .b_valid(csum_valid), .b_ready(csum_ready), .b_csum(csum_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
  );

endmodule

`default_nettype wire

//--- hw/out_stage.sv
// --------------------------------------------------------------------------
// Output stage with lane join
// Takes one entry from each lane on the same edge and registers the
// combined result record toward the output port
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

module out_stage (
  input  logic                  clk,
  input  logic                  rst,
  // Popcount lane
  input  logic                  a_valid,
  output logic                  a_ready,
  input  fj_pkg::pop_t          a_pop,
  // Checksum lane
  input  logic                  b_valid,
  output logic                  b_ready,
  input  logic [`FJ_CSUM_W-1:0] b_csum,
  // Result port
  output logic                  out_valid,
  input  logic                  out_ready,
  output fj_pkg::result_t       out_result
);

  fj_pkg::result_t result_q;
  fj_pkg::result_t joined;
  logic            valid_q;
  logic            can_load;
  logic            load;

  // ------------------------------------------------------------------------
  // Join
  // ------------------------------------------------------------------------

  // Register empty or being drained this cycle
  assign can_load = !valid_q || out_ready;
  // Pair moves only when both halves are present
  assign load     = a_valid && b_valid && can_load;
  assign a_ready  = load;
  assign b_ready  = load;

  always_comb begin
    joined.word   = a_pop.word;
    joined.count  = a_pop.count;
    joined.parity = a_pop.parity;
    joined.csum   = b_csum;
  end

  // ------------------------------------------------------------------------
  // Result register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      result_q <= joined;
    end
  end

  assign out_valid  = valid_q;
  assign out_result = result_q;

  // Lanes stay in lockstep, a transfer on one lane implies one on the other
  lockstep_a : assert property (@(posedge clk) disable iff (rst)
    (a_valid && a_ready) == (b_valid && b_ready));

endmodule

`default_nettype wire

//--- hw/pipe_stage.sv
// --------------------------------------------------------------------------
// One-entry ready/valid register stage
// Ready looks through to the downstream ready, so a full stage that is
// drained in the same cycle still accepts and throughput stays at one
// transfer per cycle
// --------------------------------------------------------------------------

`default_nettype none

module pipe_stage #(
  parameter int Width = 32
) (
  input  logic             clk,
  input  logic             rst,
  // Upstream side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [Width-1:0] in_data,
  // Downstream side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [Width-1:0] out_data
);

  logic             valid_q;
  logic [Width-1:0] data_q;
  logic             load;

  // Empty, or the held entry leaves on this edge
  assign in_ready = !valid_q || out_ready;
  assign load     = in_valid && in_ready;

  // Occupancy flag
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (out_ready) begin
      valid_q <= 1'b0;
    end
  end

  // Payload, written only on an accepting edge
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data;
    end
  end

  assign out_valid = valid_q;
  assign out_data  = data_q;

  // Stalled output holds both valid and data until the transfer
  hold_a : assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

//--- hw/popcount_lane.sv
// --------------------------------------------------------------------------
// Population-count lane
// Stage 1 counts the set bits of the word, stage 2 adds the parity bit.
// The word rides along so the output stage can rebuild the record
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

module popcount_lane (
  input  logic          clk,
  input  logic          rst,
  input  logic          in_valid,
  output logic          in_ready,
  input  fj_pkg::word_u in_word,
  output logic          out_valid,
  input  logic          out_ready,
  output fj_pkg::pop_t  out_pop
);

  fj_pkg::pop_t s1_in;
  fj_pkg::pop_t s1_out;
  fj_pkg::pop_t s2_in;
  logic         s1_valid;
  logic         s1_ready;

  // ------------------------------------------------------------------------
  // Stage 1, bit count
  // ------------------------------------------------------------------------
  always_comb begin
    s1_in.word   = in_word.raw;
    s1_in.count  = '0;
    // Parity is settled in stage 2
    s1_in.parity = 1'b0;
    for (int i = 0; i < `FJ_WORD_W; i++) begin
      s1_in.count = s1_in.count + `FJ_CNT_W'(in_word.raw[i]);
    end
  end

  pipe_stage #(.Width($bits(fj_pkg::pop_t))) u_s1 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (s1_in),
    .out_valid (s1_valid),
    .out_ready (s1_ready),
    .out_data  (s1_out)
  );

  // ------------------------------------------------------------------------
  // Stage 2, parity
  // ------------------------------------------------------------------------
  always_comb begin
    s2_in        = s1_out;
    // Odd count means odd number of ones
    s2_in.parity = s1_out.count[0];
  end

  pipe_stage #(.Width($bits(fj_pkg::pop_t))) u_s2 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (s1_valid),
    .in_ready  (s1_ready),
    .in_data   (s2_in),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_pop)
  );

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/fj_pkg.sv
hw/pipe_stage.sv
hw/flow_fork.sv
hw/popcount_lane.sv
hw/checksum_lane.sv
hw/out_stage.sv
hw/fork_join_top.sv
verif/fj_checker.sv
verif/tb_fork_join.sv

//--- verif/fj_checker.sv
// --------------------------------------------------------------------------
// Fork-join pipeline checker
// Watches both DUT handshakes, models each accepted word, and compares
// results, order, latency and stall stability at the output
// --------------------------------------------------------------------------

`default_nettype none

`include "fj_params.svh"

module fj_checker (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  input  logic            in_ready,
  input  fj_pkg::word_u   in_word,
  input  logic            out_valid,
  input  logic            out_ready,
  input  fj_pkg::result_t out_result,
  // High while every result must show the unstalled latency
  input  logic            check_latency,
  output int              error_count,
  output int              result_count,
  output int              pending
);

  // Edges from the accepting edge to the edge where out_valid rises
  localparam int result_latency = 3;

  fj_pkg::result_t exp_q[$];
  int              acc_q[$];
  int              edge_cnt = 0;
  int              errors = 0;
  int              results = 0;
  int              depth = 0;
  logic            stalled = 1'b0;
  fj_pkg::result_t held;

  assign error_count  = errors;
  assign result_count = results;
  assign pending      = depth;

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic fj_pkg::result_t expect_result(input logic [31:0] w);
    fj_pkg::result_t r;
    int ones;
    int total;
    ones  = 0;
    total = 0;
    for (int i = 0; i < `FJ_WORD_W; i++) begin
      if (w[i]) ones++;
    end
    for (int i = 0; i < `FJ_NUM_BYTES; i++) begin
      total = total + int'(w[8*i +: 8]);
    end
    // Two end-around folds, then ones' complement
    total = (total & 255) + (total >> 8);
    total = (total & 255) + (total >> 8);
    r.word   = w;
    r.count  = `FJ_CNT_W'(ones);
    r.parity = (ones % 2) == 1;
    r.csum   = ~total[7:0];
    return r;
  endfunction

  task automatic check_field(input string name, input logic [31:0] expv,
                             input logic [31:0] actv);
    if (expv !== actv) begin
      errors++;
      $display("mismatch at time %0t: out_result.%s expected 0x%0h actual 0x%0h",
               $time, name, expv, actv);
    end
  endtask

  // Edge counter, read on the falling edge where it is settled
  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  // ------------------------------------------------------------------------
  // Sampling at the falling edge, mid-cycle
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    fj_pkg::result_t exp_r;
    int              acc_edge;
    if (rst) begin
      stalled = 1'b0;
    end else begin
      // Word taken on the coming rising edge
      if (in_valid && in_ready) begin
        exp_q.push_back(expect_result(in_word.raw));
        acc_q.push_back(edge_cnt + 1);
      end
      // A stalled result must stay put
      if (stalled && !out_valid) begin
        errors++;
        $display("time %0t: out_valid dropped before the result was taken", $time);
      end else if (stalled && out_result !== held) begin
        errors++;
        $display("time %0t: out_result changed while the output was stalled", $time);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("time %0t: result transfer with no word pending", $time);
        end else begin
          exp_r    = exp_q.pop_front();
          acc_edge = acc_q.pop_front();
          results++;
          check_field("word", exp_r.word, out_result.word);
          check_field("count", 32'(exp_r.count), 32'(out_result.count));
          check_field("parity", 32'(exp_r.parity), 32'(out_result.parity));
          check_field("csum", 32'(exp_r.csum), 32'(out_result.csum));
          if (check_latency && (edge_cnt - acc_edge) != result_latency) begin
            errors++;
            $display("mismatch at time %0t: latency expected %0d actual %0d",
                     $time, result_latency, edge_cnt - acc_edge);
          end
        end
      end
      stalled = out_valid && !out_ready;
      held    = out_result;
    end
    depth = exp_q.size();
  end

endmodule

`default_nettype wire

//--- verif/tb_fork_join.sv
// --------------------------------------------------------------------------
// Fork-join pipeline testbench
// Reset, corner words, a free-running stream, random back-pressure and a
// full stall, all checked by the checker module against its model
// --------------------------------------------------------------------------

`default_nettype none

module tb_fork_join;

  localparam int num_corner = 4;
  localparam int num_free   = 500;
  localparam int num_bp     = 1000;
  localparam int num_stall  = 4;
  localparam int total_words = num_corner + num_free + num_bp + num_stall;
  localparam int cycle_limit = total_words * 8 + 100;
  localparam logic [31:0] corner_words [num_corner] =
    '{32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_00FF, 32'h8000_0001};

  logic            clk = 1'b0;
  logic            rst;
  logic            in_valid;
  logic            in_ready;
  fj_pkg::word_u   in_word;
  logic            out_valid;
  logic            out_ready;
  fj_pkg::result_t out_result;
  logic            check_latency;
  int              chk_errors;
  int              chk_results;
  int              chk_pending;
  logic [31:0]     lcg_state = 32'd32305;
  int              cycles = 0;
  int              tb_errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;
  int              errs_before = 0;

  always #5 clk = ~clk;

  fork_join_top UUT (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
    .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
  );

  fj_checker u_chk (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_ready(in_ready), .in_word(in_word),
    .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
    .check_latency(check_latency),
    .error_count(chk_errors), .result_count(chk_results), .pending(chk_pending)
  );

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run passed %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Upper halves only, the low LCG bits cycle too quickly
  task automatic rand_word(output logic [31:0] w);
    lcg_state = lcg_next(lcg_state);
    w[31:16]  = lcg_state[31:16];
    lcg_state = lcg_next(lcg_state);
    w[15:0]   = lcg_state[31:16];
  endtask

  task automatic rand_bit(output logic b);
    lcg_state = lcg_next(lcg_state);
    b = lcg_state[30];
  endtask

  // Inputs change 1 unit after the rising edge
  task automatic wait_drive();
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input string name, input logic expv, input logic actv);
    if (actv !== expv) begin
      tb_errors++;
      $display("mismatch at time %0t: %s expected %b actual %b", $time, name, expv, actv);
    end
  endtask

  // Holds the word until accepted, in_ready read a unit later once settled
  task automatic send_word(input logic [31:0] w, input bit must_accept);
    in_valid    = 1'b1;
    in_word.raw = w;
    #1;
    while (!in_ready) begin
      if (must_accept) begin
        tb_errors++;
        $display("time %0t: in_ready low during a free-running stream", $time);
      end
      @(posedge clk);
      #2;
    end
    wait_drive();
  endtask

  task automatic drain_outputs();
    int n;
    n         = 0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (chk_pending != 0 && n < 20) begin
      wait_drive();
      n++;
    end
    if (chk_pending != 0) begin
      tb_errors++;
      $display("time %0t: %0d words never reached the output", $time, chk_pending);
    end
  endtask

  task automatic finish_test(input string name);
    int delta;
    delta = tb_errors + chk_errors - errs_before;
    tests_run++;
    if (delta > 0) tests_failed++;
    $display("test %-14s %s (%0d errors)", name, (delta == 0) ? "ok" : "failed", delta);
    errs_before = tb_errors + chk_errors;
  endtask

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    logic [31:0] w;
    logic        b;
    int          sent;
    bit          holding;
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_word       = '0;
    out_ready     = 1'b0;
    check_latency = 1'b0;

    // Reset state
    wait_drive();
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("in_ready", 1'b1, in_ready);
    wait_drive();
    rst = 1'b0;
    wait_drive();
    check_bit("out_valid", 1'b0, out_valid);
    check_bit("in_ready", 1'b1, in_ready);
    finish_test("reset_state");

    // Corner words
    out_ready = 1'b1;
    for (int i = 0; i < num_corner; i++) begin
      send_word(corner_words[i], 1'b0);
    end
    drain_outputs();
    finish_test("corner_words");

    // Back-to-back stream, one result per cycle at fixed latency
    check_latency = 1'b1;
    for (int i = 0; i < num_free; i++) begin
      rand_word(w);
      send_word(w, 1'b1);
    end
    drain_outputs();
    check_latency = 1'b0;
    finish_test("free_stream");

    // Random valid and ready on both ends
    sent    = 0;
    holding = 1'b0;
    while (sent < num_bp) begin
      rand_bit(b);
      out_ready = b;
      if (!holding) begin
        rand_bit(b);
        in_valid = b;
        if (b) begin
          rand_word(w);
          in_word.raw = w;
          holding     = 1'b1;
        end
      end
      #1;
      if (in_valid && in_ready) begin
        sent++;
        holding = 1'b0;
      end
      wait_drive();
    end
    drain_outputs();
    finish_test("backpressure");

    // Fill every stage behind a stalled output
    out_ready = 1'b0;
    for (int i = 0; i < num_stall; i++) begin
      rand_word(w);
      send_word(w, 1'b0);
    end
    in_valid = 1'b0;
    repeat (10) wait_drive();
    check_bit("in_ready", 1'b0, in_ready);
    drain_outputs();
    finish_test("stall_hold");

    if (chk_results != total_words) begin
      tb_errors++;
      $display("%0d results seen for %0d words sent", chk_results, total_words);
    end
    $display("summary: %0d tests, %0d failed, %0d results, %0d errors",
             tests_run, tests_failed, chk_results, tb_errors + chk_errors);
    if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
